// File: dv/pio_tb.sv
`include "pio_cfg.svh"

module pio_tb
    import pio_pkg::*;
();

    localparam int NUM_OPS         = 400;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 200;

    logic                  sys_clk;
    logic                  rst;
    host_req_t             host_req;
    pio_rsp_t              host_rsp;
    logic [`PIO_WIDTH-1:0] pin_in  [`PIO_CHANNELS];
    logic [`PIO_WIDTH-1:0] pin_out [`PIO_CHANNELS];
    logic [`PIO_CHANNELS-1:0] irq;

    // Reference model state per channel
    logic [`PIO_WIDTH-1:0] model_out  [`PIO_CHANNELS];
    logic [`PIO_WIDTH-1:0] model_mask [`PIO_CHANNELS];
    logic [`PIO_WIDTH-1:0] model_cap  [`PIO_CHANNELS];
    logic [`PIO_WIDTH-1:0] model_pin  [`PIO_CHANNELS];

    // Outstanding reads, data and the cycle the response is due
    logic [`PIO_BUS_WIDTH-1:0] exp_data [$];
    int                        exp_due  [$];

    integer seed       = 57;
    int     cyc        = 0;
    int     quiet_from = 0;

    pio_subsystem DUT (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .pin_in   (pin_in),
        .pin_out  (pin_out),
        .irq      (irq)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on first error");
    endtask

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    // Register value zero-extended to the bus width
    function automatic logic [`PIO_BUS_WIDTH-1:0] expected_read(
        input logic [`PIO_CH_BITS-1:0] ch,
        input pio_reg_e                r
    );
        logic [`PIO_WIDTH-1:0] v;
        case (r)
            REG_DATA_IN:  v = model_pin[ch];
            REG_DATA_OUT: v = model_out[ch];
            REG_IRQ_MASK: v = model_mask[ch];
            default:      v = model_cap[ch];
        endcase
        return `PIO_BUS_WIDTH'(v);
    endfunction

    task automatic send_req(
        input logic                      wr,
        input logic                      rd,
        input logic [`PIO_CH_BITS-1:0]   ch,
        input pio_reg_e                  r,
        input logic [`PIO_BUS_WIDTH-1:0] data
    );
        @(posedge sys_clk);
        host_req.write     <= wr;
        host_req.read      <= rd;
        host_req.address   <= {ch, r};
        host_req.writedata <= data;
    endtask

    task automatic idle_cycle();
        @(posedge sys_clk);
        host_req.write <= 1'b0;
        host_req.read  <= 1'b0;
    endtask

    task automatic write_reg(
        input logic [`PIO_CH_BITS-1:0]   ch,
        input pio_reg_e                  r,
        input logic [`PIO_BUS_WIDTH-1:0] data
    );
        send_req(1'b1, 1'b0, ch, r, data);
        case (r)
            REG_DATA_OUT: model_out[ch] = data[`PIO_WIDTH-1:0];
            REG_IRQ_MASK: model_mask[ch] = data[`PIO_WIDTH-1:0];
            REG_EDGE_CAP: model_cap[ch] = model_cap[ch] & ~data[`PIO_WIDTH-1:0];
            default: ;
        endcase
        // Pins settle two edges after sampling, irq one edge later
        quiet_from = cyc + 4;
    endtask

    task automatic read_reg(input logic [`PIO_CH_BITS-1:0] ch, input pio_reg_e r);
        send_req(1'b0, 1'b1, ch, r, '0);
        exp_data.push_back(expected_read(ch, r));
        // Strobe sampled at the next edge and answered three cycles after it
        exp_due.push_back(cyc + 1 + 3);
    endtask

    // Back-to-back reads, one per channel
    task automatic read_burst();
        logic [31:0]             r;
        logic [`PIO_CH_BITS-1:0] base;
        r = rnd32();
        base = r[`PIO_CH_BITS-1:0];
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            r = rnd32();
            read_reg(base + `PIO_CH_BITS'(i), pio_reg_e'(r[1:0]));
        end
    endtask

    task automatic change_pins();
        logic [`PIO_WIDTH-1:0]   nv [`PIO_CHANNELS];
        logic [`PIO_CH_BITS-1:0] ch;
        logic [31:0]             r;
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            ch = `PIO_CH_BITS'(i);
            r = rnd32();
            nv[ch] = r[`PIO_WIDTH-1:0];
        end
        @(posedge sys_clk);
        host_req.write <= 1'b0;
        host_req.read  <= 1'b0;
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            ch = `PIO_CH_BITS'(i);
            pin_in[ch] <= nv[ch];
            // Only rising bits are captured
            model_cap[ch] = model_cap[ch] | (nv[ch] & ~model_pin[ch]);
            model_pin[ch] = nv[ch];
        end
        quiet_from = cyc + 5;
        repeat (4) idle_cycle();
    endtask

    // ------------------------------------------------------------------
    // Response and output monitor, sampled on the falling edge
    // ------------------------------------------------------------------
    always @(negedge sys_clk) begin
        logic [`PIO_CH_BITS-1:0]  idx;
        logic [`PIO_CHANNELS-1:0] exp_irq;
        cyc = cyc + 1;
        if (!rst) begin
            if (host_rsp.valid) begin
                assert (exp_data.size() != 0) else
                    stop_with_error($sformatf("Unexpected host_rsp valid in cycle %0d", cyc));
                assert (exp_due[0] == cyc) else
                    stop_with_error($sformatf("Response in cycle %0d, due in cycle %0d",
                                              cyc, exp_due[0]));
                assert (host_rsp.readdata == exp_data[0]) else
                    stop_with_error($sformatf("[ERROR] host_rsp.readdata expected %h actual %h",
                                              exp_data[0], host_rsp.readdata));
                void'(exp_data.pop_front());
                void'(exp_due.pop_front());
            end else if (exp_due.size() != 0) begin
                assert (exp_due[0] > cyc) else
                    stop_with_error($sformatf("Missing host_rsp valid for read due in cycle %0d",
                                              exp_due[0]));
            end

            if (cyc >= quiet_from) begin
                exp_irq = '0;
                for (int i = 0; i < `PIO_CHANNELS; i++) begin
                    idx = `PIO_CH_BITS'(i);
                    assert (pin_out[idx] == model_out[idx]) else
                        stop_with_error($sformatf("[ERROR] pin_out[%0d] expected %h actual %h",
                                                  i, model_out[idx], pin_out[idx]));
                    exp_irq[idx] = |(model_cap[idx] & model_mask[idx]);
                end
                assert (irq == exp_irq) else
                    stop_with_error($sformatf("[ERROR] irq expected %h actual %h",
                                              exp_irq, irq));
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]             r;
        logic [`PIO_CH_BITS-1:0] ch;
        host_req <= '0;
        rst      <= 1'b1;
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            ch = `PIO_CH_BITS'(i);
            pin_in[ch]     <= '0;
            model_out[ch]  = '0;
            model_mask[ch] = '0;
            model_cap[ch]  = '0;
            model_pin[ch]  = '0;
        end
        repeat (8) @(posedge sys_clk);
        rst <= 1'b0;

        // Quiet period, outputs must stay at their reset values
        repeat (4) idle_cycle();

        for (int op = 0; op < NUM_OPS; op++) begin
            r = rnd32();
            ch = r[4:3];
            case (r[2:0])
                3'd0:       change_pins();
                3'd1, 3'd2: write_reg(ch, pio_reg_e'(r[6:5]), rnd32());
                3'd3:       write_reg(ch, REG_DATA_OUT, rnd32());
                3'd4, 3'd5: read_reg(ch, pio_reg_e'(r[6:5]));
                3'd6:       read_burst();
                default:    idle_cycle();
            endcase
        end

        // Drain outstanding reads
        while (exp_data.size() != 0) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
        $display("** PASS **");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        stop_with_error($sformatf("Timeout after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

// File: logic/pio_cfg.svh
`ifndef PIO_CFG_SVH
`define PIO_CFG_SVH

// ----------------------------------------------------------------------
// Subsystem dimensions
// ----------------------------------------------------------------------

// Number of PIO channels behind the host bus
`define PIO_CHANNELS 4

// Pins per channel
`define PIO_WIDTH 8

// Host data width
`define PIO_BUS_WIDTH 32

// Address split, channel index above register offset
`define PIO_REG_BITS 2
`define PIO_CH_BITS 2
`define PIO_ADDR_BITS (`PIO_REG_BITS + `PIO_CH_BITS)

`endif

// File: logic/pio_channel.sv
`include "pio_cfg.svh"

module pio_channel
    import pio_pkg::*;
(
    input  logic                  sys_clk,
    input  logic                  rst,
    input  chan_req_t             req,
    output pio_rsp_t              rsp,
    input  logic [`PIO_WIDTH-1:0] pin_in,
    output logic [`PIO_WIDTH-1:0] pin_out,
    output logic                  irq
);

    // Input path
    logic [`PIO_WIDTH-1:0] sync_q1;
    logic [`PIO_WIDTH-1:0] sync_q2;
    logic [`PIO_WIDTH-1:0] prev_q;
    logic [`PIO_WIDTH-1:0] rise;

    // Register file
    logic [`PIO_WIDTH-1:0] data_out_q;
    logic [`PIO_WIDTH-1:0] irq_mask_q;
    logic [`PIO_WIDTH-1:0] edge_cap_q;

    logic [`PIO_WIDTH-1:0] clr_mask;
    logic [`PIO_WIDTH-1:0] rd_val;
    logic                  wr_out;
    logic                  wr_mask;

    // ----------------------------------------------------------------------
    // Pin synchronizer and edge detect
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= pin_in;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    assign rise = sync_q2 & ~prev_q;

    // ----------------------------------------------------------------------
    // Register writes
    // ----------------------------------------------------------------------
    assign wr_out   = req.write && (req.register == REG_DATA_OUT);
    assign wr_mask  = req.write && (req.register == REG_IRQ_MASK);
    assign clr_mask = (req.write && (req.register == REG_EDGE_CAP)) ?
                      req.writedata[`PIO_WIDTH-1:0] : '0;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            data_out_q <= '0;
            irq_mask_q <= '0;
            edge_cap_q <= '0;
            irq        <= 1'b0;
        end else begin
            if (wr_out) begin
                data_out_q <= req.writedata[`PIO_WIDTH-1:0];
            end
            if (wr_mask) begin
                irq_mask_q <= req.writedata[`PIO_WIDTH-1:0];
            end
            // New edge beats a clear on the same bit
            edge_cap_q <= (edge_cap_q & ~clr_mask) | rise;
            irq        <= |(edge_cap_q & irq_mask_q);
        end
    end

    assign pin_out = data_out_q;

    // ----------------------------------------------------------------------
    // Read response
    // ----------------------------------------------------------------------
    always_comb begin
        case (req.register)
            REG_DATA_IN:  rd_val = sync_q2;
            REG_DATA_OUT: rd_val = data_out_q;
            REG_IRQ_MASK: rd_val = irq_mask_q;
            REG_EDGE_CAP: rd_val = edge_cap_q;
            default:      rd_val = '0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.read;
        end

        // Data held between reads
        if (req.read) begin
            rsp.readdata <= {{(`PIO_BUS_WIDTH - `PIO_WIDTH){1'b0}}, rd_val};
        end
    end

endmodule

// File: logic/pio_pkg.sv
`include "pio_cfg.svh"

package pio_pkg;

    // ----------------------------------------------------------------------
    // Register map of one channel
    // ----------------------------------------------------------------------
    typedef enum logic [`PIO_REG_BITS-1:0] {
        REG_DATA_IN  = 2'd0,  // synchronized pins, read only
        REG_DATA_OUT = 2'd1,
        REG_IRQ_MASK = 2'd2,
        REG_EDGE_CAP = 2'd3   // write one to clear
    } pio_reg_e;

    // ----------------------------------------------------------------------
    // Bus payloads
    // ----------------------------------------------------------------------

    // Host side request
    typedef struct packed {
        logic                      write;
        logic                      read;
        logic [`PIO_ADDR_BITS-1:0] address;
        logic [`PIO_BUS_WIDTH-1:0] writedata;
    } host_req_t;

    // Request after decode, one per channel
    typedef struct packed {
        logic                      write;
        logic                      read;
        pio_reg_e                  register;
        logic [`PIO_BUS_WIDTH-1:0] writedata;
    } chan_req_t;

    // Read response, valid for a single cycle
    typedef struct packed {
        logic                      valid;
        logic [`PIO_BUS_WIDTH-1:0] readdata;
    } pio_rsp_t;

endpackage

// File: logic/pio_req_decoder.sv
`include "pio_cfg.svh"

module pio_req_decoder
    import pio_pkg::*;
(
    input  logic      sys_clk,
    input  logic      rst,
    input  host_req_t host_req,
    output chan_req_t chan_req [`PIO_CHANNELS]
);

    logic [`PIO_CH_BITS-1:0] ch_sel;
    pio_reg_e                reg_sel;

    // Upper address bits pick the channel, lower bits the register
    assign ch_sel  = host_req.address[`PIO_ADDR_BITS-1 -: `PIO_CH_BITS];
    assign reg_sel = pio_reg_e'(host_req.address[`PIO_REG_BITS-1:0]);

    // ----------------------------------------------------------------------
    // One registered request per channel
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            if (rst) begin
                chan_req[i].write <= 1'b0;
                chan_req[i].read  <= 1'b0;
            end else begin
                // Strobes only reach the addressed channel
                chan_req[i].write <= host_req.write && (ch_sel == `PIO_CH_BITS'(i));
                chan_req[i].read  <= host_req.read && (ch_sel == `PIO_CH_BITS'(i));
            end

            // Payload fans out to all channels
            chan_req[i].register  <= reg_sel;
            chan_req[i].writedata <= host_req.writedata;
        end
    end

endmodule

// File: logic/pio_rsp_collector.sv
`include "pio_cfg.svh"

module pio_rsp_collector
    import pio_pkg::*;
(
    input  logic     sys_clk,
    input  logic     rst,
    input  pio_rsp_t chan_rsp [`PIO_CHANNELS],
    output pio_rsp_t host_rsp
);

    logic                      any_valid;
    logic [`PIO_BUS_WIDTH-1:0] sel_data;

    // ----------------------------------------------------------------------
    // Pick the responding channel
    // ----------------------------------------------------------------------
    // Decoder strobes one channel per cycle, so at most one is valid here
    always_comb begin
        any_valid = 1'b0;
        sel_data  = '0;
        for (int i = 0; i < `PIO_CHANNELS; i++) begin
            if (chan_rsp[i].valid) begin
                any_valid = 1'b1;
                sel_data  = chan_rsp[i].readdata;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Registered host response
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            host_rsp.valid <= 1'b0;
        end else begin
            host_rsp.valid <= any_valid;
        end

        // Zero when idle
        host_rsp.readdata <= sel_data;
    end

endmodule

// File: logic/pio_subsystem.sv
`include "pio_cfg.svh"

module pio_subsystem
    import pio_pkg::*;
(
    input  logic                  sys_clk,
    input  logic                  rst,

    // Host bus
    input  host_req_t             host_req,
    output pio_rsp_t              host_rsp,

    // Pins and interrupts
    input  logic [`PIO_WIDTH-1:0] pin_in  [`PIO_CHANNELS],
    output logic [`PIO_WIDTH-1:0] pin_out [`PIO_CHANNELS],
    output logic [`PIO_CHANNELS-1:0] irq
);

    chan_req_t chan_req [`PIO_CHANNELS];
    pio_rsp_t  chan_rsp [`PIO_CHANNELS];

    // ----------------------------------------------------------------------
    // Request decode
    // ----------------------------------------------------------------------
    pio_req_decoder u_req_decoder (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .host_req (host_req),
        .chan_req (chan_req)
    );

    // ----------------------------------------------------------------------
    // Channels
    // ----------------------------------------------------------------------
    for (genvar ch = 0; ch < `PIO_CHANNELS; ch++) begin : g_chan
        pio_channel u_channel (
            .sys_clk (sys_clk),
            .rst     (rst),
            .req     (chan_req[ch]),
            .rsp     (chan_rsp[ch]),
            .pin_in  (pin_in[ch]),
            .pin_out (pin_out[ch]),
            .irq     (irq[ch])
        );
    end

    // ----------------------------------------------------------------------
    // Response merge
    // ----------------------------------------------------------------------
    pio_rsp_collector u_rsp_collector (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .chan_rsp (chan_rsp),
        .host_rsp (host_rsp)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the PIO subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module pio_tb -o pio_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/pio_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
    exit 0
fi
echo "Simulation did not report success"
exit 1

// File: sim.f
+incdir+logic
logic/pio_pkg.sv
logic/pio_req_decoder.sv
logic/pio_channel.sv
logic/pio_rsp_collector.sv
logic/pio_subsystem.sv
dv/pio_tb.sv
